//--- Bender.yml
package:
  name: uberclock_backend

sources:
  - uberclock_pkg.sv
  - path_control.sv
  - adc_front.sv
  - upsampler_feed.sv
  - tx_combiner.sv
  - dac_formatter.sv
  - uberclock_backend.sv
  - target: test
    files:
      - tb_uberclock_backend_sva.sv
      - tb_uberclock_backend.sv

//--- adc_front.sv
`timescale 1ns/1ps
`default_nettype none

module adc_front import uberclock_pkg::*; (
    input  wire logic                    sys_clk,
    input  wire logic                    rst,
    input  wire logic [ADC_W-1:0]        i_adc_data,
    input  in_sel_e                      i_in_sel,
    input  wire logic signed [DAC_W-1:0] i_system_out,
    output logic signed [ADC_W-1:0]      o_rx_input
);

    logic signed [ADC_W-1:0] adc_q;

    // ------------------------------------------------------------
    // offset binary to two's complement
    // ------------------------------------------------------------
    // flipping the msb recentres mid-scale on zero
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            adc_q <= '0;
        end else begin
            adc_q <= {~i_adc_data[ADC_W-1], i_adc_data[ADC_W-2:0]};
        end
    end

    // receive input select, combinational
    // feedback keeps the top bits of the 14-bit sum, sign intact
    always_comb begin
        case (i_in_sel)
            IN_ADC:  o_rx_input = adc_q;
            IN_ZERO: o_rx_input = '0;
            default: o_rx_input = i_system_out[DAC_W-1 -: ADC_W];
        endcase
    end

endmodule

`default_nettype wire

//--- compile.f
uberclock_pkg.sv
path_control.sv
adc_front.sv
upsampler_feed.sv
tx_combiner.sv
dac_formatter.sv
uberclock_backend.sv
tb_uberclock_backend_sva.sv
tb_uberclock_backend.sv

//--- dac_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module dac_formatter import uberclock_pkg::*; (
    input  wire logic                    sys_clk,
    input  wire logic                    rst,
    input  dac_sel_e                     i_dac1_sel,
    input  dac_sel_e                     i_dac2_sel,
    input  iq_t                          i_rx_iq [NUM_CH],
    input  wire logic signed [IQ_W-1:0]  i_tx_ch1,
    input  wire logic signed [DAC_W-1:0] i_system_out,
    output logic [DAC_W-1:0]             o_dac1,
    output logic [DAC_W-1:0]             o_dac2
);

    // mid-scale, two's complement to offset binary
    localparam logic [DAC_W-1:0] DAC_MID = DAC_W'(2**(DAC_W-1));

    logic [DAC_W-1:0] dac1_src;
    logic [DAC_W-1:0] dac2_src;

    // ------------------------------------------------------------
    // source selection
    // ------------------------------------------------------------
    // 16-bit words lose their low two bits
    always_comb begin
        case (i_dac1_sel)
            DAC_CODE0: dac1_src = i_rx_iq[0].y[IQ_W-1 -: DAC_W];
            DAC_CODE1: dac1_src = i_rx_iq[4].y[IQ_W-1 -: DAC_W];
            // nco slot, now silent
            DAC_CODE2: dac1_src = '0;
            default:   dac1_src = i_system_out;
        endcase
    end

    always_comb begin
        case (i_dac2_sel)
            DAC_CODE0: dac2_src = i_rx_iq[1].y[IQ_W-1 -: DAC_W];
            DAC_CODE1: dac2_src = i_rx_iq[2].y[IQ_W-1 -: DAC_W];
            DAC_CODE2: dac2_src = i_rx_iq[3].y[IQ_W-1 -: DAC_W];
            // tx channel 1 output
            default:   dac2_src = i_tx_ch1[IQ_W-1 -: DAC_W];
        endcase
    end

    // offset binary output registers, wrap mod 2^14
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_dac1 <= '0;
            o_dac2 <= '0;
        end else begin
            o_dac1 <= dac1_src + DAC_MID;
            o_dac2 <= dac2_src + DAC_MID;
        end
    end

endmodule

`default_nettype wire

//--- path_control.sv
`timescale 1ns/1ps
`default_nettype none

module path_control import uberclock_pkg::*; (
    input  wire logic   sys_clk,
    input  wire logic   rst,
    input  wire logic   i_ce_down,
    input  backend_cfg_t i_cfg,
    output backend_cfg_t o_cfg
);

    // ------------------------------------------------------------
    // active settings
    // ------------------------------------------------------------
    // captured only on the decimated strobe so every mux
    // switches on a sample boundary of the decimated streams
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            // adc input, gained feed, dac code 0, no shift
            o_cfg <= '0;
        end else if (i_ce_down) begin
            o_cfg <= i_cfg;
        end
    end

endmodule

`default_nettype wire

//--- tb_uberclock_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uberclock_backend import uberclock_pkg::*; ();

    localparam int          CLK_PERIOD  = 100;
    localparam int          RESET_CYC   = 4;
    // tests need roughly 1000 to 1200 cycles
    localparam int          CYCLE_LIMIT = 2000;
    localparam logic [31:0] SEED        = 32'hfb091b3b;

    logic                    sys_clk;
    logic                    rst;
    backend_cfg_t            cfg;
    logic                    ce_down;
    logic [ADC_W-1:0]        adc_data;
    iq_t                     rx_iq  [NUM_CH];
    iq_t                     cpu_iq;
    logic [GAIN_W-1:0]       gain   [NUM_CH];
    logic signed [IQ_W-1:0]  tx_out [NUM_CH];
    logic signed [ADC_W-1:0] rx_input;
    iq_t                     up_iq  [NUM_CH];
    logic signed [DAC_W-1:0] system_out;
    logic [DAC_W-1:0]        dac1;
    logic [DAC_W-1:0]        dac2;

    // reference model state
    backend_cfg_t            cfg_m;
    logic signed [ADC_W-1:0] adc_exp;
    iq_t                     up_exp [NUM_CH];
    int                      sum_d1;
    int                      sum_d2;
    int                      sum_d3;
    logic [DAC_W-1:0]        dac1_exp;
    logic [DAC_W-1:0]        dac2_exp;

    // per-test and run totals
    string cur_test     = "reset";
    int    test_checks  = 0;
    int    test_errors  = 0;
    int    total_errors = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    cycles       = 0;

    uberclock_backend uberclock_backend_inst (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .i_cfg        (cfg),
        .i_ce_down    (ce_down),
        .i_adc_data   (adc_data),
        .i_rx_iq      (rx_iq),
        .i_cpu_iq     (cpu_iq),
        .i_gain       (gain),
        .i_tx_out     (tx_out),
        .o_rx_input   (rx_input),
        .o_up_iq      (up_iq),
        .o_system_out (system_out),
        .o_dac1       (dac1),
        .o_dac2       (dac2)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD/2) sys_clk = ~sys_clk;
    end

    // ------------------------------------------------------------
    // reference functions
    // ------------------------------------------------------------
    // mid-scale offset binary code reads as zero
    function automatic logic signed [ADC_W-1:0] adc_ref(input logic [ADC_W-1:0] raw);
        return ADC_W'(int'(raw) - 2**(ADC_W-1));
    endfunction

    // 2^30 is unity gain and the result wraps to 16 bits
    function automatic logic signed [IQ_W-1:0] gain_ref(input logic signed [IQ_W-1:0] s,
                                                        input logic [GAIN_W-1:0] g);
        longint gl;
        longint prod;
        gl   = g;
        prod = longint'(s) * gl;
        return IQ_W'(prod >>> GAIN_SHIFT);
    endfunction

    function automatic iq_t feed_ref(input up_sel_e sel, input iq_t rx,
                                     input logic [GAIN_W-1:0] g, input iq_t cpu);
        iq_t r;
        case (sel)
            UP_GAINED: begin
                r.x = gain_ref(rx.x, g);
                r.y = gain_ref(rx.y, g);
            end
            UP_CPU:  r = cpu;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic int total_ref(input logic signed [IQ_W-1:0] v [NUM_CH]);
        int acc;
        acc = 0;
        foreach (v[i]) begin
            acc = acc + int'(v[i]);
        end
        return acc;
    endfunction

    // round half up, arithmetic shift, clamp to 14 bits
    function automatic logic signed [DAC_W-1:0] sys_ref(input int sum, input int shift);
        int v;
        v = sum;
        if (shift != 0) begin
            v = (v + (1 << (shift - 1))) >>> shift;
        end
        if (v > 8191) begin
            v = 8191;
        end else if (v < -8192) begin
            v = -8192;
        end
        return DAC_W'(v);
    endfunction

    function automatic int drop2(input logic signed [IQ_W-1:0] w);
        return int'(w) >>> 2;
    endfunction

    // two's complement to offset binary mod 2^14
    function automatic logic [DAC_W-1:0] offset_ref(input int v);
        return DAC_W'(v + 2**(DAC_W-1));
    endfunction

    function automatic logic [DAC_W-1:0] dac1_ref(input dac_sel_e sel, input iq_t rx [NUM_CH],
                                                  input logic signed [DAC_W-1:0] sys);
        int v;
        case (sel)
            DAC_CODE0: v = drop2(rx[0].y);
            DAC_CODE1: v = drop2(rx[NUM_CH-1].y);
            DAC_CODE2: v = 0;
            default:   v = sys;
        endcase
        return offset_ref(v);
    endfunction

    function automatic logic [DAC_W-1:0] dac2_ref(input dac_sel_e sel, input iq_t rx [NUM_CH],
                                                  input logic signed [IQ_W-1:0] tx1);
        int v;
        case (sel)
            DAC_CODE0: v = drop2(rx[1].y);
            DAC_CODE1: v = drop2(rx[2].y);
            DAC_CODE2: v = drop2(rx[3].y);
            default:   v = drop2(tx1);
        endcase
        return offset_ref(v);
    endfunction

    // ------------------------------------------------------------
    // reference model, one step per clock
    // ------------------------------------------------------------
    always @(posedge sys_clk or posedge rst) begin : model
        if (rst) begin
            cfg_m    <= '0;
            adc_exp  <= '0;
            sum_d1   <= 0;
            sum_d2   <= 0;
            sum_d3   <= 0;
            dac1_exp <= '0;
            dac2_exp <= '0;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                up_exp[ch] <= '0;
            end
        end else begin
            // settings only move on the strobe
            if (ce_down) begin
                cfg_m <= cfg;
            end
            adc_exp <= adc_ref(adc_data);
            for (int ch = 0; ch < NUM_CH; ch++) begin
                up_exp[ch] <= feed_ref(cfg_m.up_sel, rx_iq[ch], gain[ch], cpu_iq);
            end
            // three cycles of sum latency
            sum_d1   <= total_ref(tx_out);
            sum_d2   <= sum_d1;
            sum_d3   <= sum_d2;
            dac1_exp <= dac1_ref(cfg_m.dac1_sel, rx_iq, sys_ref(sum_d3, cfg_m.final_shift));
            dac2_exp <= dac2_ref(cfg_m.dac2_sel, rx_iq, tx_out[0]);
        end
    end

    task automatic note_mismatch(input string what, input longint exp, input longint act);
        test_errors++;
        total_errors++;
        $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
    endtask

    // outputs are settled by the falling edge
    always @(negedge sys_clk) begin : compare
        logic signed [DAC_W-1:0] sys_e;
        logic signed [ADC_W-1:0] rx_e;
        if (!rst) begin
            sys_e = sys_ref(sum_d3, cfg_m.final_shift);
            case (cfg_m.in_sel)
                IN_ADC:  rx_e = adc_exp;
                IN_ZERO: rx_e = '0;
                default: rx_e = ADC_W'(int'(sys_e) >>> 2);
            endcase
            test_checks++;
            if (rx_input !== rx_e) begin
                note_mismatch("o_rx_input", rx_e, rx_input);
            end
            if (system_out !== sys_e) begin
                note_mismatch("o_system_out", sys_e, system_out);
            end
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (up_iq[ch].x !== up_exp[ch].x) begin
                    note_mismatch($sformatf("o_up_iq[%0d].x", ch), up_exp[ch].x, up_iq[ch].x);
                end
                if (up_iq[ch].y !== up_exp[ch].y) begin
                    note_mismatch($sformatf("o_up_iq[%0d].y", ch), up_exp[ch].y, up_iq[ch].y);
                end
            end
            if (dac1 !== dac1_exp) begin
                note_mismatch("o_dac1", dac1_exp, dac1);
            end
            if (dac2 !== dac2_exp) begin
                note_mismatch("o_dac2", dac2_exp, dac2);
            end
        end
    end

    always @(posedge sys_clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    task automatic randomize_inputs();
        adc_data <= ADC_W'($urandom);
        cpu_iq   <= iq_t'($urandom);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            rx_iq[ch]  <= iq_t'($urandom);
            tx_out[ch] <= IQ_W'($urandom);
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge sys_clk);
            randomize_inputs();
        end
    endtask

    // one-cycle strobe along with the new settings
    task automatic load_cfg(input backend_cfg_t c);
        @(posedge sys_clk);
        cfg     <= c;
        ce_down <= 1'b1;
        @(posedge sys_clk);
        ce_down <= 1'b0;
    endtask

    task automatic hold_tx(input logic signed [IQ_W-1:0] v, input int n);
        @(posedge sys_clk);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            tx_out[ch] <= v;
        end
        repeat (n) @(posedge sys_clk);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        // drain the sum pipeline into this test's count
        repeat (4) @(posedge sys_clk);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    endtask

    initial begin : stimulus
        backend_cfg_t c;
        int           seed_val;
        seed_val = $urandom(SEED);
        rst      = 1'b0;
        cfg      = '0;
        ce_down  = 1'b0;
        adc_data = '0;
        cpu_iq   = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            rx_iq[ch]  = '0;
            gain[ch]   = '0;
            tx_out[ch] = '0;
        end
        // reset pulse starts ahead of the first clock edge
        #(CLK_PERIOD/4);
        rst = 1'b1;
        repeat (RESET_CYC) @(posedge sys_clk);
        rst <= 1'b0;

        start_test("adc_conversion");
        run_cycles(100);
        finish_test();

        // unity, one half, then random gains
        start_test("gain_scaling");
        for (int gset = 0; gset < 3; gset++) begin
            @(posedge sys_clk);
            for (int ch = 0; ch < NUM_CH; ch++) begin
                case (gset)
                    0:       gain[ch] <= 32'h4000_0000;
                    1:       gain[ch] <= 32'h2000_0000;
                    default: gain[ch] <= $urandom;
                endcase
            end
            run_cycles(60);
        end
        finish_test();

        start_test("upsampler_source");
        c        = '0;
        c.up_sel = UP_CPU;
        load_cfg(c);
        run_cycles(40);
        c.up_sel = UP_ZERO;
        c.in_sel = IN_ZERO;
        load_cfg(c);
        run_cycles(40);
        finish_test();

        // random sums then both rails for every shift
        start_test("combiner");
        for (int s = 0; s < 8; s++) begin
            c             = '0;
            c.in_sel      = IN_FEEDBACK;
            c.dac1_sel    = DAC_CODE3;
            c.final_shift = SHIFT_W'(s);
            load_cfg(c);
            run_cycles(30);
            hold_tx(16'sh7fff, 6);
            hold_tx(16'sh8000, 6);
        end
        c.final_shift = '0;
        load_cfg(c);
        hold_tx(16'sh7fff, 6);
        @(negedge sys_clk);
        test_checks++;
        if (system_out !== 14'sd8191) begin
            note_mismatch("saturated o_system_out", 8191, system_out);
        end
        finish_test();

        // each code on both dac channels with feedback on the rx input
        start_test("dac_mapping");
        for (int code = 0; code < 4; code++) begin
            c             = '0;
            c.in_sel      = IN_FEEDBACK;
            c.dac1_sel    = dac_sel_e'(code);
            c.dac2_sel    = dac_sel_e'(3 - code);
            c.final_shift = SHIFT_W'(code + 1);
            load_cfg(c);
            run_cycles(40);
        end
        finish_test();

        start_test("strobe_capture");
        c             = '0;
        c.up_sel      = UP_CPU;
        c.dac1_sel    = DAC_CODE1;
        c.dac2_sel    = DAC_CODE2;
        c.final_shift = 3'd2;
        // new settings with no strobe keep the old selection
        @(posedge sys_clk);
        cfg <= c;
        run_cycles(30);
        @(posedge sys_clk);
        ce_down <= 1'b1;
        @(posedge sys_clk);
        ce_down <= 1'b0;
        run_cycles(30);
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, total_errors,
                 uberclock_backend_inst.u_props.fail_count);
        if (total_errors == 0 && uberclock_backend_inst.u_props.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_uberclock_backend_sva.sv
`timescale 1ns/1ps
`default_nettype none

module backend_props import uberclock_pkg::*; (
    input  wire logic                    sys_clk,
    input  wire logic                    rst,
    input  wire logic                    i_ce_down,
    input  backend_cfg_t                 cfg_q,
    input  wire logic signed [IQ_W-1:0]  i_tx_out [NUM_CH],
    input  wire logic signed [DAC_W-1:0] o_system_out,
    input  wire logic [DAC_W-1:0]        o_dac1,
    input  wire logic [DAC_W-1:0]        o_dac2
);

    // failed assertions so far, read at the end of the run
    int fail_count = 0;

    // full-width sum of the channel inputs
    logic signed [IQ_W+2:0] tx_sum;

    always_comb begin
        tx_sum = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            tx_sum = tx_sum + i_tx_out[ch];
        end
    end

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------
    // clamping keeps the sign of the channel sum three cycles back
    // while a wrap into 14 bits would flip it
    system_out_clamped: assert property (
        @(posedge sys_clk) disable iff (rst)
        ($past(tx_sum, 3) >= 0) ? (o_system_out >= 0) : (o_system_out <= 0)
    ) else begin
        fail_count++;
        $error("system output wrapped instead of saturating to 14 bits");
    end

    // dac registers held at zero while in reset
    dac_zero_in_reset: assert property (
        @(posedge sys_clk)
        rst |-> (o_dac1 == '0) && (o_dac2 == '0)
    ) else begin
        fail_count++;
        $error("dac output nonzero during reset");
    end

    // active settings only move right after a strobe
    cfg_on_strobe: assert property (
        @(posedge sys_clk) disable iff (rst)
        !$stable(cfg_q) |-> $past(i_ce_down)
    ) else begin
        fail_count++;
        $error("active settings changed without a decimated strobe");
    end

endmodule

bind uberclock_backend backend_props u_props (
    .sys_clk      (sys_clk),
    .rst          (rst),
    .i_ce_down    (i_ce_down),
    .cfg_q        (cfg_q),
    .i_tx_out     (i_tx_out),
    .o_system_out (o_system_out),
    .o_dac1       (o_dac1),
    .o_dac2       (o_dac2)
);

`default_nettype wire

//--- tx_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module tx_combiner import uberclock_pkg::*; #(
    parameter int N_CH = 5
) (
    input  wire logic                   sys_clk,
    input  wire logic                   rst,
    input  wire logic [SHIFT_W-1:0]     i_final_shift,
    input  wire logic signed [IQ_W-1:0] i_tx_out [N_CH],
    output logic signed [DAC_W-1:0]     o_system_out
);

    // 16 -> 17 -> 18 -> 19 bits over the three levels
    localparam int SUM_W   = IQ_W + 3;
    localparam int SAT_MAX = 2**(DAC_W-1) - 1;
    localparam int SAT_MIN = -(2**(DAC_W-1));

    logic signed [IQ_W:0]    sum_1;
    logic signed [IQ_W:0]    sum_2;
    logic signed [IQ_W:0]    sum_3;
    logic signed [IQ_W+1:0]  sum_4;
    logic signed [IQ_W+1:0]  sum_5;
    logic signed [SUM_W-1:0] sum_final;
    logic signed [SUM_W-1:0] half;
    logic signed [SUM_W-1:0] sum_rnd;
    logic signed [SUM_W-1:0] sum_shf;

    // ------------------------------------------------------------
    // adder tree, three register levels
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            sum_1     <= '0;
            sum_2     <= '0;
            sum_3     <= '0;
            sum_4     <= '0;
            sum_5     <= '0;
            sum_final <= '0;
        end else begin
            // level 1, pairs 1+2 and 3+4
            sum_1     <= i_tx_out[0] + i_tx_out[1];
            sum_2     <= i_tx_out[2] + i_tx_out[3];
            // last channel rides along
            sum_3     <= i_tx_out[N_CH-1];
            // level 2
            sum_4     <= sum_1 + sum_2;
            sum_5     <= sum_3;
            // level 3
            sum_final <= sum_4 + sum_5;
        end
    end

    // ------------------------------------------------------------
    // round, shift, saturate
    // ------------------------------------------------------------
    // half an output lsb, only meaningful for a nonzero shift
    assign half    = SUM_W'(1) << (i_final_shift - 1'b1);
    assign sum_rnd = sum_final + half;

    always_comb begin
        if (i_final_shift == '0) begin
            sum_shf = sum_final;
        end else begin
            sum_shf = sum_rnd >>> i_final_shift;
        end
    end

    // clamp to -8192..8191
    always_comb begin
        if (sum_shf > SAT_MAX) begin
            o_system_out = DAC_W'(SAT_MAX);
        end else if (sum_shf < SAT_MIN) begin
            o_system_out = DAC_W'(SAT_MIN);
        end else begin
            o_system_out = sum_shf[DAC_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- uberclock_backend.sv
`timescale 1ns/1ps
`default_nettype none

module uberclock_backend import uberclock_pkg::*; (
    input  wire logic                   sys_clk,
    input  wire logic                   rst,
    // settings and decimated strobe
    input  backend_cfg_t                i_cfg,
    input  wire logic                   i_ce_down,
    // adc, offset binary
    input  wire logic [ADC_W-1:0]       i_adc_data,
    // channel filter chains
    input  iq_t                         i_rx_iq  [NUM_CH],
    input  iq_t                         i_cpu_iq,
    input  wire logic [GAIN_W-1:0]      i_gain   [NUM_CH],
    input  wire logic signed [IQ_W-1:0] i_tx_out [NUM_CH],
    // outputs
    output logic signed [ADC_W-1:0]     o_rx_input,
    output iq_t                         o_up_iq  [NUM_CH],
    output logic signed [DAC_W-1:0]     o_system_out,
    output logic [DAC_W-1:0]            o_dac1,
    output logic [DAC_W-1:0]            o_dac2
);

    backend_cfg_t             cfg_q;
    logic signed [DAC_W-1:0]  system_out;

    // ------------------------------------------------------------
    // settings
    // ------------------------------------------------------------
    path_control u_ctrl (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .i_ce_down (i_ce_down),
        .i_cfg     (i_cfg),
        .o_cfg     (cfg_q)
    );

    // ------------------------------------------------------------
    // receive input
    // ------------------------------------------------------------
    adc_front u_adc (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .i_adc_data   (i_adc_data),
        .i_in_sel     (cfg_q.in_sel),
        .i_system_out (system_out),
        .o_rx_input   (o_rx_input)
    );

    // gain and upsampler source per channel
    upsampler_feed #(
        .N_CH (NUM_CH)
    ) u_feed (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .i_up_sel (cfg_q.up_sel),
        .i_rx_iq  (i_rx_iq),
        .i_cpu_iq (i_cpu_iq),
        .i_gain   (i_gain),
        .o_up_iq  (o_up_iq)
    );

    // ------------------------------------------------------------
    // transmit sum and dac
    // ------------------------------------------------------------
    tx_combiner #(
        .N_CH (NUM_CH)
    ) u_comb (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_final_shift (cfg_q.final_shift),
        .i_tx_out      (i_tx_out),
        .o_system_out  (system_out)
    );

    dac_formatter u_dac (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .i_dac1_sel   (cfg_q.dac1_sel),
        .i_dac2_sel   (cfg_q.dac2_sel),
        .i_rx_iq      (i_rx_iq),
        .i_tx_ch1     (i_tx_out[0]),
        .i_system_out (system_out),
        .o_dac1       (o_dac1),
        .o_dac2       (o_dac2)
    );

    // summed output also leaves the core
    assign o_system_out = system_out;

endmodule

`default_nettype wire

//--- uberclock_pkg.sv
`default_nettype none

package uberclock_pkg;

    // ------------------------------------------------------------
    // widths and counts
    // ------------------------------------------------------------
    // rx/tx channel pairs
    localparam int NUM_CH     = 5;
    // raw adc sample
    localparam int ADC_W      = 12;
    // decimated and upsampler words
    localparam int IQ_W       = 16;
    // dac and summed system output
    localparam int DAC_W      = 14;
    // unsigned channel gain, unity at 2^GAIN_SHIFT
    localparam int GAIN_W     = 32;
    localparam int GAIN_SHIFT = 30;
    // final round/shift amount, 0..7
    localparam int SHIFT_W    = 3;

    // ------------------------------------------------------------
    // sample and settings types
    // ------------------------------------------------------------
    // one complex sample
    typedef struct packed {
        logic signed [IQ_W-1:0] x;
        logic signed [IQ_W-1:0] y;
    } iq_t;

    // receive path input, code 1 used to be the nco
    typedef enum logic [1:0] {
        IN_ADC      = 2'd0,
        IN_ZERO     = 2'd1,
        IN_FEEDBACK = 2'd2
    } in_sel_e;

    // upsampler feed, code 2 used to be the cpu tone
    typedef enum logic [1:0] {
        UP_GAINED = 2'd0,
        UP_CPU    = 2'd1,
        UP_ZERO   = 2'd2
    } up_sel_e;

    // dac source code, meaning depends on the dac channel
    typedef enum logic [1:0] {
        DAC_CODE0 = 2'd0,
        DAC_CODE1 = 2'd1,
        DAC_CODE2 = 2'd2,
        DAC_CODE3 = 2'd3
    } dac_sel_e;

    // cpu settings word, 11 bits
    typedef struct packed {
        in_sel_e              in_sel;
        up_sel_e              up_sel;
        dac_sel_e             dac1_sel;
        dac_sel_e             dac2_sel;
        logic [SHIFT_W-1:0]   final_shift;
    } backend_cfg_t;

endpackage

`default_nettype wire

//--- upsampler_feed.sv
`timescale 1ns/1ps
`default_nettype none

module upsampler_feed import uberclock_pkg::*; #(
    parameter int N_CH = 5
) (
    input  wire logic              sys_clk,
    input  wire logic              rst,
    input  up_sel_e                i_up_sel,
    input  iq_t                    i_rx_iq [N_CH],
    input  iq_t                    i_cpu_iq,
    input  wire logic [GAIN_W-1:0] i_gain  [N_CH],
    output iq_t                    o_up_iq [N_CH]
);

    // signed 16 x signed 33 product
    localparam int PROD_W = IQ_W + GAIN_W + 1;

    for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
        logic signed [GAIN_W:0]   gain_s;
        logic signed [PROD_W-1:0] prod_x;
        logic signed [PROD_W-1:0] prod_y;
        logic signed [PROD_W-1:0] shf_x;
        logic signed [PROD_W-1:0] shf_y;
        iq_t                      gained;
        iq_t                      feed;

        // --------------------------------------------------------
        // gain scaling
        // --------------------------------------------------------
        // gain is unsigned, pad a zero sign bit
        assign gain_s = {1'b0, i_gain[ch]};
        assign prod_x = i_rx_iq[ch].x * gain_s;
        assign prod_y = i_rx_iq[ch].y * gain_s;
        // 2^30 is unity
        assign shf_x  = prod_x >>> GAIN_SHIFT;
        assign shf_y  = prod_y >>> GAIN_SHIFT;
        // large gains wrap here, no saturation
        assign gained = '{x: shf_x[IQ_W-1:0], y: shf_y[IQ_W-1:0]};

        // source mux
        always_comb begin
            case (i_up_sel)
                UP_GAINED: feed = gained;
                UP_CPU:    feed = i_cpu_iq;
                default:   feed = '0;
            endcase
        end

        // one register into the upsampler
        always_ff @(posedge sys_clk or posedge rst) begin
            if (rst) begin
                o_up_iq[ch] <= '0;
            end else begin
                o_up_iq[ch] <= feed;
            end
        end
    end

endmodule

`default_nettype wire
